/* ls_pkg.sv */
// load/store unit shared types, function codes and address map
`default_nettype none

package ls_pkg;

    // data path width
    localparam int xlen = 32;

    // effective address bits 31..28 that route to the scratch memory
    localparam logic [3:0] scratch_region = 4'h0;

    // risc-v style funct3 whose low two bits give the access size
    typedef enum logic [2:0] {
        fn3_b  = 3'b000,
        fn3_h  = 3'b001,
        fn3_w  = 3'b010,
        fn3_bu = 3'b100,
        fn3_hu = 3'b101
    } ls_fn3_e;

    // sub-unit chosen by address region
    typedef enum logic {
        unit_scratch = 1'b0,
        unit_bus     = 1'b1
    } ls_unit_e;

    // input queue entry
    typedef struct packed {
        logic                load;
        logic                store;
        ls_fn3_e             fn3;
        logic [xlen-1:0]     base;
        logic signed [11:0]  offset;
        logic [xlen-1:0]     store_data;
    } ls_req_t;

endpackage

`default_nettype wire

/* ls_sub_unit_if.sv */
// request and return signals between issue logic, one memory sub-unit and the return path
`timescale 1ns/1ns
`default_nettype none

interface ls_sub_unit_if;

    // issue side
    logic                     new_request;
    logic [ls_pkg::xlen-1:0]  addr;
    logic                     load;
    logic                     store;
    logic [3:0]               be;
    logic [ls_pkg::xlen-1:0]  data_in;

    // sub-unit side with data_out zero outside data_valid
    logic                     ready;
    logic                     data_valid;
    logic [ls_pkg::xlen-1:0]  data_out;

    modport issue (output new_request, addr, load, store, be, data_in, input ready);
    modport unit (input new_request, addr, load, store, be, data_in,
                  output ready, data_valid, data_out);
    modport ret (input data_valid, data_out);

endinterface

`default_nettype wire

/* ls_issue.sv */
// input queue, effective address, alignment check, byte enables and sub-unit issue control
`timescale 1ns/1ns
`default_nettype none

module ls_issue #(
    parameter int queue_depth = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic                    req_load,
    input  logic                    req_store,
    input  ls_pkg::ls_fn3_e         req_fn3,
    input  logic [ls_pkg::xlen-1:0] req_base,
    input  logic signed [11:0]      req_offset,
    input  logic [ls_pkg::xlen-1:0] req_store_data,
    input  logic                    result_taken,
    output logic                    misaligned,
    output logic                    load_push,
    output ls_pkg::ls_fn3_e         load_fn3,
    output logic [1:0]              load_byte_addr,
    ls_sub_unit_if.issue            scratch,
    ls_sub_unit_if.issue            bus
);

    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);

    ls_pkg::ls_req_t          queue_mem [queue_depth];
    ls_pkg::ls_req_t          push_entry;
    ls_pkg::ls_req_t          head;
    logic [ptr_w-1:0]         wr_ptr;
    logic [ptr_w-1:0]         rd_ptr;
    logic [cnt_w-1:0]         count;
    logic                     ready_en;
    logic                     push;
    logic                     pop;
    logic                     head_valid;
    logic [ls_pkg::xlen-1:0]  eff_addr;
    logic                     unaligned;
    ls_pkg::ls_unit_e         unit_sel;
    ls_pkg::ls_unit_e         last_unit;
    logic                     unit_ready;
    logic                     unit_stall;
    logic [1:0]               inflight;
    logic                     issue;
    logic                     drop;
    logic                     drop_q;
    logic [3:0]               be;
    logic [ls_pkg::xlen-1:0]  store_data;

    // queue write side
    assign push_entry = '{load: req_load, store: req_store, fn3: req_fn3, base: req_base,
                          offset: req_offset, store_data: req_store_data};
    assign req_ready  = ready_en && (count != cnt_w'(queue_depth));
    assign push       = req_valid & req_ready;
    assign pop        = issue | drop;
    assign head_valid = (count != '0);
    assign head       = queue_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push)
            queue_mem[wr_ptr] <= push_entry;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            ready_en <= 1'b0;
        end else begin
            // hold off requests for one cycle out of reset
            ready_en <= 1'b1;
            if (push)
                wr_ptr <= (wr_ptr == ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // base plus sign-extended offset
    assign eff_addr = head.base + {{(ls_pkg::xlen-12){head.offset[11]}}, head.offset};

    always_comb begin
        case (head.fn3)
            ls_pkg::fn3_h, ls_pkg::fn3_hu: unaligned = eff_addr[0];
            ls_pkg::fn3_w:                 unaligned = |eff_addr[1:0];
            default:                       unaligned = 1'b0;
        endcase
    end

    // region decode on the top nibble
    assign unit_sel   = (eff_addr[31:28] == ls_pkg::scratch_region) ? ls_pkg::unit_scratch
                                                                     : ls_pkg::unit_bus;
    assign unit_ready = (unit_sel == ls_pkg::unit_scratch) ? scratch.ready : bus.ready;
    // switching units with loads outstanding could reorder returns
    assign unit_stall = (unit_sel != last_unit) && (inflight != 2'd0);
    assign issue      = head_valid & ~unaligned & unit_ready & (inflight < 2'd2) & ~unit_stall;
    // one drop per two cycles keeps the pulse single
    assign drop       = head_valid & unaligned & ~drop_q;
    assign misaligned = drop;

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight  <= 2'd0;
            last_unit <= ls_pkg::unit_scratch;
            drop_q    <= 1'b0;
        end else begin
            drop_q <= drop;
            if (issue)
                last_unit <= unit_sel;
            // load counted from issue until its result leaves the buffer
            if (load_push && !result_taken)
                inflight <= inflight + 2'd1;
            else if (result_taken && !load_push)
                inflight <= inflight - 2'd1;
        end
    end

    // byte enables only for stores
    always_comb begin
        be = 4'b0000;
        if (head.store) begin
            case (head.fn3[1:0])
                2'b00:   be[eff_addr[1:0]] = 1'b1;
                2'b01:   be = eff_addr[1] ? 4'b1100 : 4'b0011;
                default: be = 4'b1111;
            endcase
        end
    end

    // lane replication so any byte enable sees the right bits
    always_comb begin
        case (head.fn3[1:0])
            2'b00:   store_data = {4{head.store_data[7:0]}};
            2'b01:   store_data = {2{head.store_data[15:0]}};
            default: store_data = head.store_data;
        endcase
    end

    assign load_push      = issue & head.load;
    assign load_fn3       = head.fn3;
    assign load_byte_addr = eff_addr[1:0];

    assign scratch.new_request = issue & (unit_sel == ls_pkg::unit_scratch);
    assign scratch.addr        = eff_addr;
    assign scratch.load        = head.load;
    assign scratch.store       = head.store;
    assign scratch.be          = be;
    assign scratch.data_in     = store_data;

    assign bus.new_request = issue & (unit_sel == ls_pkg::unit_bus);
    assign bus.addr        = eff_addr;
    assign bus.load        = head.load;
    assign bus.store       = head.store;
    assign bus.be          = be;
    assign bus.data_in     = store_data;

endmodule

`default_nettype wire

/* ls_scratch_mem.sv */
// local scratch memory with byte-enabled writes and a fixed one-cycle read
`timescale 1ns/1ns
`default_nettype none

module ls_scratch_mem #(
    parameter int scratch_words = 256
) (
    input  logic        clk,
    input  logic        rst,
    ls_sub_unit_if.unit port
);

    localparam int idx_w = (scratch_words > 1) ? $clog2(scratch_words) : 1;

    logic [ls_pkg::xlen-1:0] mem [scratch_words];
    logic [ls_pkg::xlen-1:0] rd_data;
    logic [idx_w-1:0]        word_idx;
    logic                    valid_q;

    // word address with upper bits past the depth wrapping
    assign word_idx = port.addr[idx_w+1:2];

    always_ff @(posedge clk) begin
        if (port.new_request && port.store) begin
            for (int i = 0; i < 4; i++) begin
                if (port.be[i])
                    mem[word_idx][i*8 +: 8] <= port.data_in[i*8 +: 8];
            end
        end
        // registered read
        if (port.new_request && port.load)
            rd_data <= mem[word_idx];
    end

    always_ff @(posedge clk) begin
        if (rst)
            valid_q <= 1'b0;
        else
            valid_q <= port.new_request & port.load;
    end

    // never busy
    assign port.ready      = 1'b1;
    assign port.data_valid = valid_q;
    // zero outside valid so the return path can OR units together
    assign port.data_out   = valid_q ? rd_data : '0;

endmodule

`default_nettype wire

/* ls_apb_master.sv */
// APB master carrying one sub-unit request at a time to the external bus
`timescale 1ns/1ns
`default_nettype none

module ls_apb_master (
    input  logic                    clk,
    input  logic                    rst,
    output logic [ls_pkg::xlen-1:0] paddr,
    output logic                    psel,
    output logic                    penable,
    output logic                    pwrite,
    output logic [ls_pkg::xlen-1:0] pwdata,
    output logic [3:0]              pstrb,
    input  logic [ls_pkg::xlen-1:0] prdata,
    input  logic                    pready,
    ls_sub_unit_if.unit             port
);

    typedef enum logic [1:0] {
        apb_idle,
        apb_setup,
        apb_access
    } apb_state_e;

    apb_state_e              state;
    logic [ls_pkg::xlen-1:0] addr_q;
    logic [ls_pkg::xlen-1:0] wdata_q;
    logic [ls_pkg::xlen-1:0] rdata_q;
    logic [3:0]              strb_q;
    logic                    write_q;
    logic                    valid_q;
    logic                    take;
    logic                    done;

    assign take = port.new_request && (state == apb_idle);
    assign done = (state == apb_access) && pready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= apb_idle;
            valid_q <= 1'b0;
        end else begin
            valid_q <= done & ~write_q;
            case (state)
                apb_idle:   if (take) state <= apb_setup;
                apb_setup:  state <= apb_access;
                apb_access: if (pready) state <= apb_idle;
                default:    state <= apb_idle;
            endcase
        end
    end

    // request held for the whole transfer
    always_ff @(posedge clk) begin
        if (take) begin
            addr_q  <= {port.addr[ls_pkg::xlen-1:2], 2'b00};
            wdata_q <= port.data_in;
            strb_q  <= port.be;
            write_q <= port.store;
        end
        if (done && !write_q)
            rdata_q <= prdata;
    end

    assign paddr   = addr_q;
    assign psel    = (state != apb_idle);
    assign penable = (state == apb_access);
    assign pwrite  = write_q;
    assign pwdata  = wdata_q;
    assign pstrb   = strb_q;

    // next request only once the bus is free
    assign port.ready      = (state == apb_idle);
    assign port.data_valid = valid_q;
    assign port.data_out   = valid_q ? rdata_q : '0;

endmodule

`default_nettype wire

/* ls_load_return.sv */
// load data merge, lane alignment, sign extension and two-entry result buffer
`timescale 1ns/1ns
`default_nettype none

module ls_load_return (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_push,
    input  ls_pkg::ls_fn3_e         load_fn3,
    input  logic [1:0]              load_byte_addr,
    input  logic                    result_ready,
    output logic                    result_valid,
    output logic [ls_pkg::xlen-1:0] result_data,
    output logic                    result_taken,
    ls_sub_unit_if.ret              scratch,
    ls_sub_unit_if.ret              bus
);

    ls_pkg::ls_fn3_e         attr_fn3 [2];
    logic [1:0]              attr_addr [2];
    logic                    attr_wr;
    logic                    attr_rd;
    logic                    data_valid;
    logic [ls_pkg::xlen-1:0] raw_data;
    logic [7:0]              byte_lane;
    logic [15:0]             half_lane;
    logic [ls_pkg::xlen-1:0] final_data;
    logic [ls_pkg::xlen-1:0] slot0;
    logic [ls_pkg::xlen-1:0] slot1;
    logic [1:0]              res_count;

    // attribute ring with depth bounded by the in-flight limit
    always_ff @(posedge clk) begin
        if (load_push) begin
            attr_fn3[attr_wr]  <= load_fn3;
            attr_addr[attr_wr] <= load_byte_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            attr_wr <= 1'b0;
            attr_rd <= 1'b0;
        end else begin
            if (load_push)
                attr_wr <= ~attr_wr;
            if (data_valid)
                attr_rd <= ~attr_rd;
        end
    end

    // idle units drive zero
    assign data_valid = scratch.data_valid | bus.data_valid;
    assign raw_data   = scratch.data_out | bus.data_out;

    assign byte_lane = raw_data[attr_addr[attr_rd]*8 +: 8];
    assign half_lane = attr_addr[attr_rd][1] ? raw_data[31:16] : raw_data[15:0];

    always_comb begin
        case (attr_fn3[attr_rd])
            ls_pkg::fn3_b:  final_data = {{24{byte_lane[7]}}, byte_lane};
            ls_pkg::fn3_h:  final_data = {{16{half_lane[15]}}, half_lane};
            ls_pkg::fn3_bu: final_data = {24'd0, byte_lane};
            ls_pkg::fn3_hu: final_data = {16'd0, half_lane};
            default:        final_data = raw_data;
        endcase
    end

    assign result_valid = (res_count != 2'd0);
    assign result_data  = slot0;
    assign result_taken = result_valid & result_ready;

    // slot0 is the head and slot1 fills only behind a waiting head
    always_ff @(posedge clk) begin
        if (data_valid && (res_count == 2'd0 || (res_count == 2'd1 && result_taken)))
            slot0 <= final_data;
        else if (result_taken)
            slot0 <= slot1;
        if (data_valid && (res_count == 2'd1 || res_count == 2'd2) &&
            !(res_count == 2'd1 && result_taken))
            slot1 <= final_data;
    end

    always_ff @(posedge clk) begin
        if (rst)
            res_count <= 2'd0;
        else if (data_valid && !result_taken)
            res_count <= res_count + 2'd1;
        else if (result_taken && !data_valid)
            res_count <= res_count - 2'd1;
    end

endmodule

`default_nettype wire

/* load_store_unit.sv */
// load/store unit top with scratch memory, APB master and ordered result port
`timescale 1ns/1ns
`default_nettype none

module load_store_unit #(
    parameter int queue_depth   = 4,
    parameter int scratch_words = 256
) (
    input  logic                    clk,
    input  logic                    rst,
    // request side
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic                    req_load,
    input  logic                    req_store,
    input  ls_pkg::ls_fn3_e         req_fn3,
    input  logic [ls_pkg::xlen-1:0] req_base,
    input  logic signed [11:0]      req_offset,
    input  logic [ls_pkg::xlen-1:0] req_store_data,
    // result side
    output logic                    result_valid,
    output logic [ls_pkg::xlen-1:0] result_data,
    input  logic                    result_ready,
    output logic                    misaligned,
    // external bus
    output logic [ls_pkg::xlen-1:0] paddr,
    output logic                    psel,
    output logic                    penable,
    output logic                    pwrite,
    output logic [ls_pkg::xlen-1:0] pwdata,
    output logic [3:0]              pstrb,
    input  logic [ls_pkg::xlen-1:0] prdata,
    input  logic                    pready
);

    logic            result_taken;
    logic            load_push;
    ls_pkg::ls_fn3_e load_fn3;
    logic [1:0]      load_byte_addr;

    ls_sub_unit_if scratch_if ();
    ls_sub_unit_if bus_if ();

    ls_issue #(.queue_depth(queue_depth)) i_issue (
        .clk, .rst, .req_valid, .req_ready, .req_load, .req_store, .req_fn3,
        .req_base, .req_offset, .req_store_data, .result_taken, .misaligned,
        .load_push, .load_fn3, .load_byte_addr,
        .scratch (scratch_if.issue),
        .bus     (bus_if.issue)
    );

    ls_scratch_mem #(.scratch_words(scratch_words)) i_scratch_mem (
        .clk, .rst,
        .port (scratch_if.unit)
    );

    ls_apb_master i_apb_master (
        .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .pstrb, .prdata, .pready,
        .port (bus_if.unit)
    );

    ls_load_return i_load_return (
        .clk, .rst, .load_push, .load_fn3, .load_byte_addr, .result_ready,
        .result_valid, .result_data, .result_taken,
        .scratch (scratch_if.ret),
        .bus     (bus_if.ret)
    );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// testbench clock source with a 20 ns period and a ten cycle synchronous reset
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held over the first ten rising edges
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

`default_nettype wire

/* tb_ls_chk.sv */
// APB and result port protocol assertions bound into the load/store unit
`timescale 1ns/1ns
`default_nettype none

module tb_ls_chk (
    input logic                    clk,
    input logic                    rst,
    input logic                    psel,
    input logic                    penable,
    input logic                    pready,
    input logic [ls_pkg::xlen-1:0] paddr,
    input logic                    result_valid,
    input logic                    result_ready,
    input logic [ls_pkg::xlen-1:0] result_data,
    input logic                    misaligned
);

    // failure count read by the testbench top
    int fail_count = 0;

    // setup phase lasts one cycle
    a_setup_to_access: assert property (@(posedge clk) disable iff (rst)
        psel && !penable |=> psel && penable)
        else begin
            $error("penable did not follow the APB setup phase");
            fail_count++;
        end

    // address held from setup until the transfer completes
    a_paddr_stable: assert property (@(posedge clk) disable iff (rst)
        psel && !(penable && pready) |=> $stable(paddr))
        else begin
            $error("paddr changed during an APB transfer");
            fail_count++;
        end

    a_result_hold: assert property (@(posedge clk) disable iff (rst)
        result_valid && !result_ready |=> result_valid && $stable(result_data))
        else begin
            $error("result dropped or changed while stalled");
            fail_count++;
        end

    // single cycle pulse
    a_misaligned_pulse: assert property (@(posedge clk) disable iff (rst)
        misaligned |=> !misaligned)
        else begin
            $error("misaligned held for two cycles");
            fail_count++;
        end

endmodule

`default_nettype wire

/* tb_load_store_unit.sv */
// testbench for the load/store unit with file driven requests, APB slave model and result checks
`timescale 1ns/1ns
`default_nettype none

module tb_load_store_unit;

    localparam int max_rows     = 40;
    localparam int row_words    = 7;
    localparam int accept_limit = 500;
    localparam int drain_limit  = 2000;

    // one expected APB transfer
    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic [3:0]  strb;
        logic [31:0] wait_cnt;
    } apb_exp_t;

    logic               clk;
    logic               rst;
    logic               req_valid;
    logic               req_ready;
    logic               req_load;
    logic               req_store;
    ls_pkg::ls_fn3_e    req_fn3;
    logic [31:0]        req_base;
    logic signed [11:0] req_offset;
    logic [31:0]        req_store_data;
    logic               result_valid;
    logic [31:0]        result_data;
    logic               result_ready;
    logic               misaligned;
    logic [31:0]        paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [31:0]        pwdata;
    logic [3:0]         pstrb;
    logic [31:0]        prdata;
    logic               pready;

    logic [31:0] stim [0:max_rows*row_words-1];
    logic [31:0] exp_results [$];
    apb_exp_t    apb_exp [$];
    logic [31:0] bus_mem [logic [29:0]];
    logic [31:0] exp_data;
    int          check_count;
    int          error_count;
    int          misaligned_seen;
    int          misaligned_expected;
    logic        saw_full;
    logic        timed_out;

    tb_clk_gen i_clk_gen (.clk(clk), .rst(rst));

    load_store_unit #(.queue_depth(4), .scratch_words(256)) i_dut (.*);

    bind load_store_unit tb_ls_chk i_chk (.*);

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // byte lanes a bus transfer should enable and none for reads
    function automatic logic [3:0] expected_strobe(input logic store, input logic [1:0] size,
                                                   input logic [1:0] lane);
        if (!store)
            return 4'b0000;
        case (size)
            2'b00:   return 4'b0001 << lane;
            2'b01:   return lane[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    // halfword needs an even address and word needs both low bits clear
    function automatic logic is_misaligned(input logic [1:0] size, input logic [1:0] lane);
        return ((size == 2'b01) && lane[0]) || ((size == 2'b10) && (lane != 2'b00));
    endfunction

    // contents of a bus word never written
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_a5a5;
    endfunction

    // drive one file row and record what it should produce once accepted
    task automatic send_request(input int row);
        logic [31:0] op;
        logic [31:0] fn3_code;
        logic [31:0] addr;
        logic [11:0] off;
        logic [1:0]  size;
        apb_exp_t    tr;
        int          tries;
        op       = stim[row * row_words];
        fn3_code = stim[row * row_words + 1];
        off      = stim[row * row_words + 3][11:0];
        addr     = stim[row * row_words + 2] + {{20{off[11]}}, off};
        size     = fn3_code[1:0];
        req_valid      = 1'b1;
        req_load       = (op == 32'd1);
        req_store      = (op == 32'd2);
        req_fn3        = ls_pkg::ls_fn3_e'(fn3_code[2:0]);
        req_base       = stim[row * row_words + 2];
        req_offset     = off;
        req_store_data = stim[row * row_words + 4];
        tries = 0;
        while (!req_ready && tries < accept_limit) begin
            saw_full = 1'b1;
            @(posedge clk);
            #2;
            tries++;
        end
        if (!req_ready) begin
            report_error($sformatf("request in row %0d was never accepted", row));
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
            if (is_misaligned(size, addr[1:0])) begin
                misaligned_expected++;
            end else begin
                if (op == 32'd1)
                    exp_results.push_back(stim[row * row_words + 5]);
                // bus region transfers appear on APB in issue order
                if (addr[31:28] != ls_pkg::scratch_region) begin
                    tr.addr     = {addr[31:2], 2'b00};
                    tr.write    = (op == 32'd2);
                    tr.strb     = expected_strobe(op == 32'd2, size, addr[1:0]);
                    tr.wait_cnt = stim[row * row_words + 6];
                    apb_exp.push_back(tr);
                end
            end
            #2;
        end
        req_valid = 1'b0;
    endtask

    // APB slave with a word memory and per transfer wait states
    initial begin : apb_slave
        apb_exp_t    cur;
        int          wait_left;
        logic        busy;
        logic [31:0] word;
        pready    = 1'b0;
        prdata    = '0;
        busy      = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            #2;
            pready = 1'b0;
            prdata = '0;
            if (!rst && psel && penable) begin
                // first access cycle of a transfer
                if (!busy) begin
                    busy = 1'b1;
                    cur  = '0;
                    if (apb_exp.size() == 0)
                        report_error("APB transfer with no bus request pending");
                    else
                        cur = apb_exp.pop_front();
                    check_value("paddr", paddr, cur.addr);
                    check_value("pwrite", {31'd0, pwrite}, {31'd0, cur.write});
                    check_value("pstrb", {28'd0, pstrb}, {28'd0, cur.strb});
                    wait_left = (cur.wait_cnt == 32'hffff_ffff) ? int'($urandom_range(0, 4))
                                                                : int'(cur.wait_cnt);
                end
                if (wait_left == 0) begin
                    word = bus_mem.exists(paddr[31:2]) ? bus_mem[paddr[31:2]] : fill_word(paddr);
                    if (pwrite) begin
                        for (int b = 0; b < 4; b++) begin
                            if (pstrb[b])
                                word[b*8 +: 8] = pwdata[b*8 +: 8];
                        end
                        bus_mem[paddr[31:2]] = word;
                    end else begin
                        prdata = word;
                    end
                    pready = 1'b1;
                    busy   = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // long stall every 150 cycles with random gaps in between
    initial begin : result_pressure
        int cyc;
        result_ready = 1'b0;
        cyc = 0;
        forever begin
            @(posedge clk);
            #2;
            if (rst) begin
                result_ready = 1'b0;
            end else begin
                if ((cyc % 150) < 50)
                    result_ready = 1'b0;
                else
                    result_ready = ($urandom_range(0, 3) != 0);
                cyc++;
            end
        end
    end

    // mid-cycle sampling of result handshake and misaligned pulses
    always @(negedge clk) begin
        if (!rst) begin
            if (misaligned)
                misaligned_seen++;
            if (result_valid && result_ready) begin
                if (exp_results.size() == 0) begin
                    report_error("result returned with no load outstanding");
                end else begin
                    exp_data = exp_results.pop_front();
                    check_value("result_data", result_data, exp_data);
                end
            end
        end
    end

    initial begin : main
        int tries;
        int row;
        void'($urandom(32'h4b39_f5ce));
        req_valid           = 1'b0;
        req_load            = 1'b0;
        req_store           = 1'b0;
        req_fn3             = ls_pkg::fn3_w;
        req_base            = '0;
        req_offset          = '0;
        req_store_data      = '0;
        check_count         = 0;
        error_count         = 0;
        misaligned_seen     = 0;
        misaligned_expected = 0;
        saw_full            = 1'b0;
        timed_out           = 1'b0;
        for (int k = 0; k < max_rows * row_words; k++)
            stim[k] = '0;
        $readmemh("ls_stimulus.txt", stim);
        tries = 0;
        while (rst !== 1'b0 && tries < 50) begin
            @(posedge clk);
            tries++;
        end
        if (rst !== 1'b0) begin
            report_error("reset was never released");
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
            #2;
        end
        // op of zero ends the table
        row = 0;
        while (!timed_out && row < max_rows && stim[row * row_words] != 32'd0) begin
            send_request(row);
            row++;
        end
        tries = 0;
        while (!timed_out && (exp_results.size() != 0 || apb_exp.size() != 0)) begin
            if (tries == drain_limit) begin
                report_error("outstanding loads or bus transfers never completed");
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
                tries++;
            end
        end
        // room for any stray result or pulse
        repeat (5) @(posedge clk);
        check_value("misaligned pulses", 32'(misaligned_seen), 32'(misaligned_expected));
        if (!saw_full)
            report_error("req_ready never fell under result back-pressure");
        if (i_dut.i_chk.fail_count != 0)
            report_error($sformatf("%0d protocol assertions failed", i_dut.i_chk.fail_count));
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* ls_stimulus.txt */
// columns op fn3 base offset store_data expected pready_wait
// op 1 loads and op 2 stores. a wait of ffffffff draws a random pready delay
2 2 00000100 004 11223344 00000000 0
1 2 00000100 004 00000000 11223344 0
2 2 00000110 000 a1b2c3d4 00000000 0
2 0 00000110 001 deadbe85 00000000 0
2 1 00000110 002 beeff00e 00000000 0
1 0 00000110 001 00000000 ffffff85 0
1 4 00000110 001 00000000 00000085 0
1 1 00000110 002 00000000 fffff00e 0
1 5 00000110 002 00000000 0000f00e 0
1 0 00000110 000 00000000 ffffffd4 0
1 1 00000110 000 00000000 ffff85d4 0
1 2 00000110 000 00000000 f00e85d4 0
2 2 00000120 ffc 7f008001 00000000 0
1 1 00000120 ffe 00000000 00007f00 0
1 0 00000120 ffc 00000000 00000001 0
2 2 10000040 000 cafebabe 00000000 2
2 0 10000040 001 00000012 00000000 0
2 1 10000040 002 00008765 00000000 ffffffff
1 2 10000040 000 00000000 876512be 3
1 0 10000040 003 00000000 ffffff87 ffffffff
1 5 10000040 002 00000000 00008765 1
1 4 10000040 001 00000000 00000012 0
1 2 00000100 004 00000000 11223344 0
1 2 10000040 000 00000000 876512be 1
1 2 00000110 000 00000000 f00e85d4 0
1 1 10000040 000 00000000 000012be ffffffff
1 1 10000040 001 00000000 00000000 0
1 2 00000100 002 00000000 00000000 0
1 2 00000100 004 00000000 11223344 0

/* tb.f */
ls_pkg.sv
ls_sub_unit_if.sv
ls_issue.sv
ls_scratch_mem.sv
ls_apb_master.sv
ls_load_return.sv
load_store_unit.sv
tb_clk_gen.sv
tb_ls_chk.sv
tb_load_store_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_load_store_unit \
    -f tb.f -o sim_tb \
    && ./obj_dir/sim_tb +verilator+error+limit+1000 2>&1 | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }
grep -qx "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
